/* rtl/i2c_pkg.sv */
package i2c_pkg;

    localparam int BITS_PER_BYTE = 8;
    localparam int DIVIDER_WIDTH = 16;
    localparam int ADDRESS_WIDTH = 7;

    typedef logic [BITS_PER_BYTE-1:0] byte_t;

    // Quarter-bit position inside one SCL period
    typedef logic [1:0] phase_t;

    typedef enum logic [3:0] {
        S_IDLE       = 4'd0,
        S_START      = 4'd1,
        S_ADDR_W     = 4'd2,
        S_CHECK_ACK  = 4'd3,
        S_REG_ADDR   = 4'd4,
        S_RESTART    = 4'd5,
        S_ADDR_R     = 4'd6,
        S_READ_DATA  = 4'd7,
        S_SEND_ACK   = 4'd8,
        S_SEND_NACK  = 4'd9,
        S_WRITE_DATA = 4'd10,
        S_STOP       = 4'd11
    } seq_state_t;

endpackage

/* rtl/i2c_byte_if.sv */
`timescale 1ns/100ps

interface i2c_byte_if;
    import i2c_pkg::*;

    // Strobes from the sequencer, one clock wide
    logic  load;
    byte_t load_byte;
    logic  shift_out;
    logic  shift_in;
    logic  rx_bit;

    // Shifter state seen by the sequencer
    logic  tx_bit;
    byte_t rx_byte;

    modport ctrl (
        output load, load_byte, shift_out, shift_in, rx_bit,
        input  tx_bit, rx_byte
    );

    modport shift (
        input  load, load_byte, shift_out, shift_in, rx_bit,
        output tx_bit, rx_byte
    );

endinterface

/* rtl/i2c_bus_timer.sv */
`timescale 1ns/100ps

module i2c_bus_timer #(
    parameter int STRETCH_TIMER_WIDTH = 16,
    parameter int STRETCH_MAX_TICKS   = 255
) (
    input  logic                              clock,
    input  logic                              reset_n,
    input  logic [i2c_pkg::DIVIDER_WIDTH-1:0] divider,
    input  logic                              stretch_restart,
    output logic                              tick,
    output logic                              stretch_expired
);
    import i2c_pkg::*;

    localparam logic [STRETCH_TIMER_WIDTH-1:0] MAX_COUNT =
        STRETCH_TIMER_WIDTH'(STRETCH_MAX_TICKS);
    localparam bit TIMEOUT_ON = (STRETCH_MAX_TICKS != 0);

    logic [DIVIDER_WIDTH-1:0]       divider_count;
    logic [STRETCH_TIMER_WIDTH-1:0] stretch_count;

    ////////////////////
    // Bit-rate divider

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            divider_count <= '0;
            tick          <= 1'b0;
        end else if (divider_count == divider) begin
            divider_count <= '0;
            tick          <= 1'b1;
        end else begin
            divider_count <= divider_count + 1'b1;
            tick          <= 1'b0;
        end
    end

    ////////////////////
    // Stretch timeout, counted in ticks

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            stretch_count <= '0;
        end else if (stretch_restart) begin
            stretch_count <= '0;
        end else if (tick && !stretch_expired) begin
            stretch_count <= stretch_count + 1'b1;
        end
    end

    // Never fires when the limit is zero
    assign stretch_expired = TIMEOUT_ON && (stretch_count == MAX_COUNT);

endmodule

/* rtl/i2c_byte_shifter.sv */
`timescale 1ns/100ps

module i2c_byte_shifter (
    input  logic     clock,
    input  logic     reset_n,
    i2c_byte_if.shift bus
);
    import i2c_pkg::*;

    byte_t shift_reg;

    // Load wins over either shift
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            shift_reg <= '0;
        end else if (bus.load) begin
            shift_reg <= bus.load_byte;
        end else if (bus.shift_out) begin
            // Rotate so the next bit sits at the MSB
            shift_reg <= {shift_reg[BITS_PER_BYTE-2:0], shift_reg[BITS_PER_BYTE-1]};
        end else if (bus.shift_in) begin
            shift_reg <= {shift_reg[BITS_PER_BYTE-2:0], bus.rx_bit};
        end
    end

    assign bus.tx_bit  = shift_reg[BITS_PER_BYTE-1];
    assign bus.rx_byte = shift_reg;

endmodule

/* rtl/i2c_sequencer.sv */
`timescale 1ns/100ps

module i2c_sequencer #(
    parameter int DATA_BYTES = 1,
    parameter int REG_BYTES  = 1
) (
    input  logic                                               clock,
    input  logic                                               reset_n,
    input  logic                                               enable,
    input  logic                                               read_write,
    input  logic [i2c_pkg::ADDRESS_WIDTH-1:0]                  device_address,
    input  logic [REG_BYTES-1:0][i2c_pkg::BITS_PER_BYTE-1:0]   register_address,
    input  logic [DATA_BYTES-1:0][i2c_pkg::BITS_PER_BYTE-1:0]  mosi_data,
    input  logic                                               tick,
    input  logic                                               stretch_expired,
    input  logic                                               scl_in,
    input  logic                                               sda_in,
    output logic                                               stretch_restart,
    output logic                                               scl_drive_low,
    output logic                                               sda_drive_low,
    output logic [DATA_BYTES-1:0][i2c_pkg::BITS_PER_BYTE-1:0]  miso_data,
    output logic                                               busy,
    i2c_byte_if.ctrl                                           bytes
);
    import i2c_pkg::*;

    localparam int MAX_BYTES   = (DATA_BYTES > REG_BYTES) ? DATA_BYTES : REG_BYTES;
    localparam int COUNT_WIDTH = $clog2(MAX_BYTES + 1);

    seq_state_t             state;
    seq_state_t             post_state;
    phase_t                 phase;
    logic [3:0]             bit_count;
    logic [COUNT_WIDTH-1:0] byte_count;
    logic                   ack_ok;

    logic                     rw_q;
    logic [ADDRESS_WIDTH-1:0] dev_q;
    byte_t [REG_BYTES-1:0]    reg_q;
    byte_t [DATA_BYTES-1:0]   data_q;

    logic start_req;
    logic load_next;
    logic write_state;
    logic tx_next;

    assign start_req   = (state == S_IDLE) && !busy && enable;
    assign load_next   = tick && (phase == 2'd2) && (state == S_CHECK_ACK);
    assign write_state = state inside {S_ADDR_W, S_REG_ADDR, S_ADDR_R, S_WRITE_DATA};

    // Phase 3 puts the shifter MSB on SDA
    assign tx_next = (state == S_START) ||
                     (write_state && bit_count != 4'd0) ||
                     (state == S_CHECK_ACK && ack_ok &&
                      post_state inside {S_REG_ADDR, S_WRITE_DATA});

    assign stretch_restart = (phase == 2'd0);
    assign bytes.rx_bit    = sda_in;

    ////////////////////
    // Shifter strobes

    always_comb begin
        bytes.load      = 1'b0;
        bytes.load_byte = '0;
        bytes.shift_out = tick && (phase == 2'd3) && tx_next;
        bytes.shift_in  = tick && (phase == 2'd2) && (state == S_READ_DATA);

        if (tick && phase == 2'd2 && state == S_START) begin
            bytes.load      = 1'b1;
            bytes.load_byte = {dev_q, post_state == S_ADDR_R};
        end else if (load_next && post_state == S_REG_ADDR) begin
            bytes.load      = 1'b1;
            bytes.load_byte = reg_q[REG_BYTES-1];
        end else if (load_next && post_state == S_WRITE_DATA) begin
            bytes.load      = 1'b1;
            bytes.load_byte = data_q[DATA_BYTES-1];
        end
    end

    // Captured request, top byte goes first
    always_ff @(posedge clock) begin
        if (start_req) begin
            rw_q   <= read_write;
            dev_q  <= device_address;
            reg_q  <= register_address;
            data_q <= mosi_data;
        end else if (load_next) begin
            if (post_state == S_REG_ADDR) reg_q <= reg_q << BITS_PER_BYTE;
            if (post_state == S_WRITE_DATA) data_q <= data_q << BITS_PER_BYTE;
        end
    end

    ////////////////////
    // Transaction FSM

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state         <= S_IDLE;
            post_state    <= S_IDLE;
            phase         <= '0;
            bit_count     <= '0;
            byte_count    <= '0;
            ack_ok        <= 1'b0;
            scl_drive_low <= 1'b0;
            sda_drive_low <= 1'b0;
            miso_data     <= '0;
            busy          <= 1'b0;
        end else if (start_req) begin
            state      <= S_START;
            post_state <= S_ADDR_W;
            busy       <= 1'b1;
        end else if (tick && state != S_IDLE) begin
            phase <= phase + 1'b1;
            case (phase)
                2'd0: begin
                    scl_drive_low <= 1'b0;
                end
                2'd1: begin
                    if (state == S_START) begin
                        // START or repeated START
                        sda_drive_low <= 1'b1;
                    end else if (!scl_in) begin
                        // Target is stretching SCL
                        phase <= 2'd1;
                        if (stretch_expired) begin
                            state         <= S_IDLE;
                            phase         <= '0;
                            scl_drive_low <= 1'b0;
                            sda_drive_low <= 1'b0;
                            busy          <= 1'b0;
                        end
                    end
                end
                2'd2: begin
                    if (state != S_STOP && state != S_RESTART) scl_drive_low <= 1'b1;
                    if (write_state || state == S_READ_DATA) bit_count <= bit_count - 1'b1;
                    if (state == S_CHECK_ACK) ack_ok <= !sda_in;
                    // STOP, SDA rises with SCL high
                    if (state == S_STOP) sda_drive_low <= 1'b0;
                end
                default: begin
                    if (tx_next) sda_drive_low <= !bytes.tx_bit;
                    case (state)
                        S_START: begin
                            state     <= post_state;
                            bit_count <= 4'(BITS_PER_BYTE);
                        end
                        S_ADDR_W: if (bit_count == 4'd0) begin
                            state         <= S_CHECK_ACK;
                            sda_drive_low <= 1'b0;
                            post_state    <= S_REG_ADDR;
                            byte_count    <= COUNT_WIDTH'(REG_BYTES);
                        end
                        S_ADDR_R: if (bit_count == 4'd0) begin
                            state         <= S_CHECK_ACK;
                            sda_drive_low <= 1'b0;
                            post_state    <= S_READ_DATA;
                            byte_count    <= COUNT_WIDTH'(DATA_BYTES);
                        end
                        S_REG_ADDR: if (bit_count == 4'd0) begin
                            state         <= S_CHECK_ACK;
                            sda_drive_low <= 1'b0;
                            byte_count    <= byte_count - 1'b1;
                            if (byte_count != 1) begin
                                post_state <= S_REG_ADDR;
                            end else if (rw_q) begin
                                post_state <= S_RESTART;
                            end else begin
                                post_state <= S_WRITE_DATA;
                                byte_count <= COUNT_WIDTH'(DATA_BYTES);
                            end
                        end
                        S_WRITE_DATA: if (bit_count == 4'd0) begin
                            state         <= S_CHECK_ACK;
                            sda_drive_low <= 1'b0;
                            byte_count    <= byte_count - 1'b1;
                            post_state    <= (byte_count == 1) ? S_STOP : S_WRITE_DATA;
                        end
                        S_CHECK_ACK: begin
                            bit_count <= 4'(BITS_PER_BYTE);
                            if (!ack_ok) begin
                                // NACK, finish with STOP
                                state         <= S_STOP;
                                sda_drive_low <= 1'b1;
                            end else begin
                                state <= post_state;
                                if (post_state == S_STOP) sda_drive_low <= 1'b1;
                                if (post_state inside {S_RESTART, S_READ_DATA}) begin
                                    sda_drive_low <= 1'b0;
                                end
                                if (post_state == S_READ_DATA) begin
                                    miso_data <= miso_data << BITS_PER_BYTE;
                                end
                            end
                        end
                        S_RESTART: begin
                            state      <= S_START;
                            post_state <= S_ADDR_R;
                        end
                        S_READ_DATA: begin
                            miso_data[0] <= bytes.rx_byte;
                            if (bit_count == 4'd0) begin
                                byte_count <= byte_count - 1'b1;
                                if (byte_count == 1) begin
                                    // SDA stays released for the NACK
                                    state <= S_SEND_NACK;
                                end else begin
                                    state         <= S_SEND_ACK;
                                    sda_drive_low <= 1'b1;
                                end
                            end
                        end
                        S_SEND_ACK: begin
                            state         <= S_READ_DATA;
                            sda_drive_low <= 1'b0;
                            bit_count     <= 4'(BITS_PER_BYTE);
                            miso_data     <= miso_data << BITS_PER_BYTE;
                        end
                        S_SEND_NACK: begin
                            state         <= S_STOP;
                            sda_drive_low <= 1'b1;
                        end
                        S_STOP: begin
                            state <= S_IDLE;
                            busy  <= 1'b0;
                        end
                        default: begin
                            state <= S_IDLE;
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

/* rtl/i2c_master.sv */
`timescale 1ns/100ps

module i2c_master #(
    parameter int DATA_BYTES          = 1,
    parameter int REG_BYTES           = 1,
    parameter int STRETCH_TIMER_WIDTH = 16,
    parameter int STRETCH_MAX_TICKS   = 255
) (
    input  logic                                         clock,
    input  logic                                         reset_n,
    input  logic                                         enable,
    input  logic                                         read_write,
    input  logic [i2c_pkg::ADDRESS_WIDTH-1:0]            device_address,
    input  logic [REG_BYTES*i2c_pkg::BITS_PER_BYTE-1:0]  register_address,
    input  logic [DATA_BYTES*i2c_pkg::BITS_PER_BYTE-1:0] mosi_data,
    input  logic [i2c_pkg::DIVIDER_WIDTH-1:0]            divider,
    input  logic                                         scl_in,
    input  logic                                         sda_in,
    output logic                                         scl_drive_low,
    output logic                                         sda_drive_low,
    output logic [DATA_BYTES*i2c_pkg::BITS_PER_BYTE-1:0] miso_data,
    output logic                                         busy
);

    logic tick;
    logic stretch_expired;
    logic stretch_restart;

    i2c_byte_if byte_bus ();

    i2c_bus_timer #(
        .STRETCH_TIMER_WIDTH (STRETCH_TIMER_WIDTH),
        .STRETCH_MAX_TICKS   (STRETCH_MAX_TICKS)
    ) u_timer (
        .clock           (clock),
        .reset_n         (reset_n),
        .divider         (divider),
        .stretch_restart (stretch_restart),
        .tick            (tick),
        .stretch_expired (stretch_expired)
    );

    i2c_byte_shifter u_shifter (
        .clock   (clock),
        .reset_n (reset_n),
        .bus     (byte_bus.shift)
    );

    // Pads are open drain, so only pull-low enables leave the core
    i2c_sequencer #(
        .DATA_BYTES (DATA_BYTES),
        .REG_BYTES  (REG_BYTES)
    ) u_sequencer (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .mosi_data        (mosi_data),
        .tick             (tick),
        .stretch_expired  (stretch_expired),
        .scl_in           (scl_in),
        .sda_in           (sda_in),
        .stretch_restart  (stretch_restart),
        .scl_drive_low    (scl_drive_low),
        .sda_drive_low    (sda_drive_low),
        .miso_data        (miso_data),
        .busy             (busy),
        .bytes            (byte_bus.ctrl)
    );

endmodule

/* bench/i2c_target_model.sv */
`timescale 1ns/100ps

module i2c_target_model #(
    parameter logic [6:0] ADDRESS = 7'h2a
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic [15:0] stretch_clocks,
    input  logic        scl,
    input  logic        sda,
    output logic        scl_low,
    output logic        sda_low
);

    logic [7:0]  mem [256];
    logic        scl_q;
    logic        sda_q;
    logic        active;
    logic        reading;
    logic        in_ack;
    logic        in_mack;
    logic        mack_ok;
    // 0 address, 1 register, 2 data
    logic [1:0]  byte_kind;
    logic [3:0]  bit_idx;
    logic [7:0]  sr;
    logic [7:0]  ptr;
    logic [15:0] stretch_left;

    always @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= 8'(i) ^ 8'h5a;
            end
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            active       <= 1'b0;
            reading      <= 1'b0;
            in_ack       <= 1'b0;
            in_mack      <= 1'b0;
            mack_ok      <= 1'b0;
            byte_kind    <= 2'd0;
            bit_idx      <= 4'd0;
            sr           <= 8'h00;
            ptr          <= 8'h00;
            scl_low      <= 1'b0;
            sda_low      <= 1'b0;
            stretch_left <= 16'd0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;

            ////////////////////
            // Clock stretching after each falling SCL edge
            if (stretch_left != 16'd0) begin
                stretch_left <= stretch_left - 16'd1;
                if (stretch_left == 16'd1) begin
                    scl_low <= 1'b0;
                end
            end else if (scl_q && !scl && stretch_clocks != 16'd0) begin
                scl_low      <= 1'b1;
                stretch_left <= stretch_clocks;
            end

            ////////////////////
            // Bus protocol
            if (scl && scl_q && sda_q && !sda) begin
                // START or repeated START
                active    <= 1'b1;
                reading   <= 1'b0;
                in_ack    <= 1'b0;
                in_mack   <= 1'b0;
                byte_kind <= 2'd0;
                bit_idx   <= 4'd0;
                sda_low   <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin
                active  <= 1'b0;
                sda_low <= 1'b0;
            end else if (active && scl && !scl_q) begin
                if (in_mack) begin
                    mack_ok <= !sda;
                end else if (!in_ack) begin
                    bit_idx <= bit_idx + 4'd1;
                    if (!reading) begin
                        sr <= {sr[6:0], sda};
                    end
                end
            end else if (active && !scl && scl_q) begin
                if (in_ack || (in_mack && mack_ok)) begin
                    in_ack  <= 1'b0;
                    in_mack <= 1'b0;
                    bit_idx <= 4'd0;
                    sda_low <= 1'b0;
                    if (reading) begin
                        sr      <= mem[ptr];
                        ptr     <= ptr + 8'd1;
                        sda_low <= !mem[ptr][7];
                    end
                end else if (in_mack) begin
                    // Master NACK, wait for STOP
                    in_mack <= 1'b0;
                    active  <= 1'b0;
                end else if (bit_idx == 4'd8) begin
                    if (reading) begin
                        sda_low <= 1'b0;
                        in_mack <= 1'b1;
                    end else begin
                        in_ack  <= 1'b1;
                        sda_low <= 1'b1;
                        case (byte_kind)
                            2'd0: begin
                                if (sr[7:1] == ADDRESS) begin
                                    reading   <= sr[0];
                                    byte_kind <= 2'd1;
                                end else begin
                                    active  <= 1'b0;
                                    in_ack  <= 1'b0;
                                    sda_low <= 1'b0;
                                end
                            end
                            2'd1: begin
                                ptr       <= sr;
                                byte_kind <= 2'd2;
                            end
                            default: begin
                                mem[ptr] <= sr;
                                ptr      <= ptr + 8'd1;
                            end
                        endcase
                    end
                end else if (reading) begin
                    sr      <= {sr[6:0], 1'b0};
                    sda_low <= !sr[6];
                end
            end
        end
    end

endmodule

/* bench/i2c_master_chk.sv */
`timescale 1ns/100ps

module i2c_master_chk (
    input logic clock,
    input logic reset_n,
    input logic enable,
    input logic busy,
    input logic scl_drive_low,
    input logic sda_drive_low
);

    // Bus released outside a transfer
    a_idle_released: assert property (@(posedge clock) disable iff (!reset_n)
        !busy |-> (!scl_drive_low && !sda_drive_low))
        else $error("bus pulled low while not busy");

    a_busy_needs_enable: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(busy) |-> $past(enable))
        else $error("busy rose without enable");

endmodule

bind i2c_master i2c_master_chk chk (
    .clock         (clock),
    .reset_n       (reset_n),
    .enable        (enable),
    .busy          (busy),
    .scl_drive_low (scl_drive_low),
    .sda_drive_low (sda_drive_low)
);

/* bench/tb_i2c_master.sv */
`timescale 1ns/100ps

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int DATA_BYTES    = 2;
    localparam int REG_BYTES     = 1;
    localparam int DIVIDER       = 3;
    localparam int MAX_TICKS     = 16;
    localparam int PERIOD        = 40;
    localparam int NUM_ROWS      = 8;
    localparam int SHORT_STRETCH = 6 * (DIVIDER + 1);
    localparam int LONG_STRETCH  = 40 * (DIVIDER + 1);
    localparam int ROW_CLOCKS    = 44 * (4 * (DIVIDER + 1) + LONG_STRETCH);
    localparam int WATCHDOG_NS   = (NUM_ROWS * ROW_CLOCKS + 2000) * PERIOD;
    localparam logic [6:0] TARGET = 7'h2a;

    typedef struct packed {
        logic        rw;
        logic [6:0]  dev;
        byte_t       reg_addr;
        logic [15:0] data;
        logic        random_data;
        logic [15:0] stretch;
        logic        completes;
    } row_t;

    logic        clock = 1'b0;
    logic        reset_n;
    logic        enable;
    logic        read_write;
    logic [6:0]  device_address;
    logic [7:0]  register_address;
    logic [15:0] mosi_data;
    logic [15:0] divider;
    logic        scl_in;
    logic        sda_in;
    logic        scl_drive_low;
    logic        sda_drive_low;
    logic [15:0] miso_data;
    logic        busy;
    logic        target_scl_low;
    logic        target_sda_low;
    logic [15:0] stretch_clocks;

    row_t        rows [NUM_ROWS];
    byte_t       exp_mem [256];
    logic [15:0] exp_miso;
    logic [31:0] lfsr_state;

    // Open-drain lines with pull-ups
    assign scl_in = !(scl_drive_low || target_scl_low);
    assign sda_in = !(sda_drive_low || target_sda_low);

    always #(PERIOD / 2) clock = ~clock;

    i2c_master #(
        .DATA_BYTES          (DATA_BYTES),
        .REG_BYTES           (REG_BYTES),
        .STRETCH_TIMER_WIDTH (16),
        .STRETCH_MAX_TICKS   (MAX_TICKS)
    ) dut (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .mosi_data        (mosi_data),
        .divider          (divider),
        .scl_in           (scl_in),
        .sda_in           (sda_in),
        .scl_drive_low    (scl_drive_low),
        .sda_drive_low    (sda_drive_low),
        .miso_data        (miso_data),
        .busy             (busy)
    );

    i2c_target_model #(.ADDRESS(TARGET)) target (
        .clock          (clock),
        .reset_n        (reset_n),
        .stretch_clocks (stretch_clocks),
        .scl            (scl_in),
        .sda            (sda_in),
        .scl_low        (target_scl_low),
        .sda_low        (target_sda_low)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 32'h80200003;
        return n;
    endfunction

    function automatic byte_t random_byte();
        byte_t b;
        b = '0;
        for (int i = 0; i < BITS_PER_BYTE; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
        return b;
    endfunction

    function automatic row_t make_row(input logic rw, input logic [6:0] dev,
                                      input byte_t reg_addr, input logic random_data,
                                      input logic [15:0] stretch, input logic completes);
        row_t r;
        r.rw          = rw;
        r.dev         = dev;
        r.reg_addr    = reg_addr;
        r.data        = 16'h0000;
        r.random_data = random_data;
        r.stretch     = stretch;
        r.completes   = completes;
        return r;
    endfunction

    task automatic load_table();
        rows[0] = make_row(1'b0, TARGET, 8'h10, 1'b1, 16'd0, 1'b1);
        rows[1] = make_row(1'b1, TARGET, 8'h10, 1'b0, 16'd0, 1'b1);
        // Wrong address, NACKed
        rows[2] = make_row(1'b0, 7'h33, 8'h10, 1'b1, 16'd0, 1'b0);
        rows[3] = make_row(1'b1, 7'h33, 8'h10, 1'b0, 16'd0, 1'b0);
        rows[4] = make_row(1'b0, TARGET, 8'h80, 1'b1, 16'(SHORT_STRETCH), 1'b1);
        rows[5] = make_row(1'b1, TARGET, 8'h80, 1'b0, 16'(SHORT_STRETCH), 1'b1);
        // Stretch beyond the timeout
        rows[6] = make_row(1'b0, TARGET, 8'h40, 1'b1, 16'(LONG_STRETCH), 1'b0);
        rows[7] = make_row(1'b1, TARGET, 8'h10, 1'b0, 16'd0, 1'b1);
    endtask

    task automatic report_failure(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_data(input logic [DATA_BYTES*BITS_PER_BYTE-1:0] actual,
                              input logic [DATA_BYTES*BITS_PER_BYTE-1:0] expected,
                              input string what);
        if (actual !== expected)
            report_failure($sformatf("%s: got %h, expected %h", what, actual, expected));
    endtask

    task automatic check_byte(input byte_t actual, input byte_t expected, input string what);
        if (actual !== expected)
            report_failure($sformatf("%s: got %h, expected %h", what, actual, expected));
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            report_failure($sformatf("%s: got %b, expected %b", what, actual, expected));
    endtask

    task automatic run_transfer(input row_t r, input logic [15:0] data);
        @(posedge clock);
        #2;
        read_write       = r.rw;
        device_address   = r.dev;
        register_address = r.reg_addr;
        mosi_data        = data;
        stretch_clocks   = r.stretch;
        enable           = 1'b1;
        @(posedge clock);
        #2;
        enable = 1'b0;
        check_flag(busy, 1'b1, "busy after enable");
        while (busy) begin
            @(posedge clock);
            #2;
        end
        // Let a stretching target let go of the bus
        while (!(scl_in && sda_in)) begin
            @(posedge clock);
            #2;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run timed out at %0t ns", $time);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        row_t        r;
        logic [15:0] data;
        byte_t       next_reg;

        reset_n          = 1'b0;
        enable           = 1'b0;
        read_write       = 1'b0;
        device_address   = '0;
        register_address = '0;
        mosi_data        = '0;
        divider          = 16'(DIVIDER);
        stretch_clocks   = '0;
        lfsr_state       = 32'hdebe;
        exp_miso         = '0;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = 8'(i) ^ 8'h5a;
        end
        load_table();

        repeat (4) @(posedge clock);
        #2;
        reset_n = 1'b1;

        ////////////////////
        // Idle after reset
        repeat (8) begin
            @(posedge clock);
            #2;
            check_flag(busy, 1'b0, "busy idle after reset");
            check_flag(scl_drive_low, 1'b0, "scl released after reset");
            check_flag(sda_drive_low, 1'b0, "sda released after reset");
        end
        check_data(miso_data, '0, "miso_data after reset");

        ////////////////////
        // Transaction table
        for (int n = 0; n < NUM_ROWS; n++) begin
            r        = rows[n];
            data     = r.data;
            next_reg = r.reg_addr + 8'd1;
            if (r.random_data) begin
                data[15:8] = random_byte();
                data[7:0]  = random_byte();
            end
            run_transfer(r, data);

            if (r.completes && !r.rw) begin
                exp_mem[r.reg_addr] = data[15:8];
                exp_mem[next_reg]   = data[7:0];
            end
            if (r.completes && r.rw) exp_miso = {exp_mem[r.reg_addr], exp_mem[next_reg]};

            check_data(miso_data, exp_miso, $sformatf("row %0d miso_data", n));
            check_byte(target.mem[r.reg_addr], exp_mem[r.reg_addr],
                       $sformatf("row %0d memory at %h", n, r.reg_addr));
            check_byte(target.mem[next_reg], exp_mem[next_reg],
                       $sformatf("row %0d memory at %h", n, next_reg));
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* tb.f */
rtl/i2c_pkg.sv
rtl/i2c_byte_if.sv
rtl/i2c_bus_timer.sv
rtl/i2c_byte_shifter.sv
rtl/i2c_sequencer.sv
rtl/i2c_master.sv
bench/i2c_target_model.sv
bench/i2c_master_chk.sv
bench/tb_i2c_master.sv

/* run.sh */
#!/bin/sh
# Build and run the I2C master testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_i2c_master -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
